// File: design/decodePacker.sv
`timescale 1ns/1ps
`default_nettype none

module decodePacker #(
  parameter int FETCH_WIDTH = frontEndPkg::DEF_FETCH_WIDTH,
  localparam int CNT_W = $clog2(FETCH_WIDTH + 1)
) (
  input  logic                                       clk,
  input  logic                                       rstN_i,
  input  logic                                       flush_i,
  input  logic                                       fetchValid_i,
  input  logic [FETCH_WIDTH-1:0]                     fetchVector_i,
  input  logic [FETCH_WIDTH*frontEndPkg::OP_W-1:0]   fetchOp_i,
  input  logic [FETCH_WIDTH*frontEndPkg::PC_W-1:0]   fetchPc_i,
  input  logic [FETCH_WIDTH*frontEndPkg::IMM_W-1:0]  fetchImm_i,
  output logic                                       packValid_o,
  output logic [CNT_W-1:0]                           packCount_o,
  output logic [FETCH_WIDTH*frontEndPkg::PKT_W-1:0]  packData_o
);
  import frontEndPkg::*;

  // Compacted bundle, before the register.
  logic [FETCH_WIDTH*PKT_W-1:0] packedData;
  logic [CNT_W-1:0]             packedCount;

  // Walk the slots in order.
  // Each valid one lands in the next free low slot.
  always_comb begin : packSlots
    int unsigned slot;
    instOpE      slotOp;
    packedData = '0;
    slot       = 0;
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      // Classify the slot from its opcode field.
      slotOp = instOpE'(fetchOp_i[i*OP_W +: OP_W]);
      if (fetchVector_i[i]) begin
        packedData[slot*PKT_W +: PKT_W] = {slotOp,
                                           fetchPc_i[i*PC_W +: PC_W],
                                           fetchImm_i[i*IMM_W +: IMM_W]};
        slot++;
      end
    end
    // Number of valid slots, 0 to FETCH_WIDTH.
    packedCount = CNT_W'(slot);
  end

  // Strobe and count of the registered bundle.
  // A flush drops the bundle in flight.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      packValid_o <= 1'b0;
      packCount_o <= '0;
    end else begin
      packValid_o <= fetchValid_i;
      packCount_o <= fetchValid_i ? packedCount : '0;
    end
  end

  // Packet payload.
  // Only loaded on a strobe.
  always_ff @(posedge clk) begin
    if (fetchValid_i) begin
      packData_o <= packedData;
    end
  end

  // Count stays within the bundle width.
  assert property (@(posedge clk) disable iff (!rstN_i)
    packValid_o |-> (packCount_o <= CNT_W'(FETCH_WIDTH)))
    else $error("decodePacker: packCount_o above FETCH_WIDTH");

endmodule

`default_nettype wire

// File: design/dispatchGroup.sv
`timescale 1ns/1ps
`default_nettype none

module dispatchGroup #(
  parameter int DISPATCH_WIDTH = frontEndPkg::DEF_DISPATCH_WIDTH,
  localparam int CNT_W = $clog2(DISPATCH_WIDTH + 1)
) (
  input  logic                                         clk,
  input  logic                                         rstN_i,
  input  logic                                         flush_i,
  input  logic                                         backendStall_i,
  input  logic                                         groupReady_i,
  input  logic [DISPATCH_WIDTH*frontEndPkg::PKT_W-1:0] groupData_i,
  output logic                                         groupTake_o,
  output logic                                         dispatchValid_o,
  output logic [DISPATCH_WIDTH*frontEndPkg::PKT_W-1:0] dispatchData_o,
  output logic [CNT_W-1:0]                             branchCount_o,
  output logic [CNT_W-1:0]                             memCount_o
);
  import frontEndPkg::*;

  // Output register holds a valid group or not.
  typedef enum logic {
    dispIdle   = 1'b0,
    dispActive = 1'b1
  } dispStateE;

  dispStateE        state;
  logic [CNT_W-1:0] branchCount;
  logic [CNT_W-1:0] memCount;

  // Take whenever a full group waits and the back end is free.
  assign groupTake_o = groupReady_i && !backendStall_i;

  // Class counts over the head group.
  always_comb begin : countClasses
    instOpE slotOp;
    branchCount = '0;
    memCount    = '0;
    for (int g = 0; g < DISPATCH_WIDTH; g++) begin
      slotOp = instOpE'(groupData_i[g*PKT_W + OP_LSB +: OP_W]);
      if (slotOp == OP_BRANCH) begin
        branchCount = branchCount + 1'b1;
      end
      // Loads and stores both count as memory ops.
      if (slotOp == OP_LOAD || slotOp == OP_STORE) begin
        memCount = memCount + 1'b1;
      end
    end
  end

  // State and counts.
  // Valid only for the cycle after a take.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      state         <= dispIdle;
      branchCount_o <= '0;
      memCount_o    <= '0;
    end else if (groupTake_o) begin
      state         <= dispActive;
      branchCount_o <= branchCount;
      memCount_o    <= memCount;
    end else begin
      state         <= dispIdle;
      branchCount_o <= '0;
      memCount_o    <= '0;
    end
  end

  // Group payload.
  always_ff @(posedge clk) begin
    if (groupTake_o) begin
      dispatchData_o <= groupData_i;
    end
  end

  assign dispatchValid_o = (state == dispActive);

endmodule

`default_nettype wire

// File: design/frontEndPkg.sv
`default_nettype none

package frontEndPkg;

  // Instruction class, delivered ready made by fetch.
  typedef enum logic [1:0] {
    OP_ALU    = 2'd0,
    OP_LOAD   = 2'd1,
    OP_STORE  = 2'd2,
    OP_BRANCH = 2'd3
  } instOpE;

  // Field widths.
  localparam int OP_W  = 2;
  localparam int PC_W  = 16;
  localparam int IMM_W = 8;

  // Packet layout, MSB first: {op, pc, imm}.
  localparam int PKT_W  = OP_W + PC_W + IMM_W;
  localparam int OP_LSB = PC_W + IMM_W;

  // Default front-end geometry.
  localparam int DEF_FETCH_WIDTH    = 4;
  localparam int DEF_DISPATCH_WIDTH = 2;
  // Power of two, at least 2*FETCH_WIDTH + DISPATCH_WIDTH.
  localparam int DEF_QUEUE_DEPTH    = 16;

endpackage

`default_nettype wire

// File: design/frontEndTop.sv
`timescale 1ns/1ps
`default_nettype none

module frontEndTop #(
  parameter int FETCH_WIDTH    = frontEndPkg::DEF_FETCH_WIDTH,
  parameter int DISPATCH_WIDTH = frontEndPkg::DEF_DISPATCH_WIDTH,
  parameter int QUEUE_DEPTH    = frontEndPkg::DEF_QUEUE_DEPTH,
  localparam int DCNT_W = $clog2(DISPATCH_WIDTH + 1)
) (
  input  logic                                         clk,
  input  logic                                         rstN_i,
  input  logic                                         flush_i,
  input  logic                                         fetchValid_i,
  input  logic [FETCH_WIDTH-1:0]                       fetchVector_i,
  input  logic [FETCH_WIDTH*frontEndPkg::OP_W-1:0]     fetchOp_i,
  input  logic [FETCH_WIDTH*frontEndPkg::PC_W-1:0]     fetchPc_i,
  input  logic [FETCH_WIDTH*frontEndPkg::IMM_W-1:0]    fetchImm_i,
  input  logic                                         backendStall_i,
  output logic                                         fetchStall_o,
  output logic                                         dispatchValid_o,
  output logic [DISPATCH_WIDTH*frontEndPkg::PKT_W-1:0] dispatchData_o,
  output logic [DCNT_W-1:0]                            branchCount_o,
  output logic [DCNT_W-1:0]                            memCount_o
);
  import frontEndPkg::*;

  localparam int FCNT_W = $clog2(FETCH_WIDTH + 1);

  // Packer to buffer.
  logic                         packValid;
  logic [FCNT_W-1:0]            packCount;
  logic [FETCH_WIDTH*PKT_W-1:0] packData;

  // Buffer to consumer and back.
  logic                            groupReady;
  logic [DISPATCH_WIDTH*PKT_W-1:0] groupData;
  logic                            groupTake;

  decodePacker #(
    .FETCH_WIDTH(FETCH_WIDTH)
  ) packer (
    .clk          (clk),
    .rstN_i       (rstN_i),
    .flush_i      (flush_i),
    .fetchValid_i (fetchValid_i),
    .fetchVector_i(fetchVector_i),
    .fetchOp_i    (fetchOp_i),
    .fetchPc_i    (fetchPc_i),
    .fetchImm_i   (fetchImm_i),
    .packValid_o  (packValid),
    .packCount_o  (packCount),
    .packData_o   (packData)
  );

  instBuffer #(
    .QUEUE_DEPTH   (QUEUE_DEPTH),
    .FETCH_WIDTH   (FETCH_WIDTH),
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) buffer (
    .clk         (clk),
    .rstN_i      (rstN_i),
    .flush_i     (flush_i),
    .packValid_i (packValid),
    .packCount_i (packCount),
    .packData_i  (packData),
    .groupTake_i (groupTake),
    .groupReady_o(groupReady),
    .groupData_o (groupData),
    .fetchStall_o(fetchStall_o)
  );

  dispatchGroup #(
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) dispatch (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .flush_i        (flush_i),
    .backendStall_i (backendStall_i),
    .groupReady_i   (groupReady),
    .groupData_i    (groupData),
    .groupTake_o    (groupTake),
    .dispatchValid_o(dispatchValid_o),
    .dispatchData_o (dispatchData_o),
    .branchCount_o  (branchCount_o),
    .memCount_o     (memCount_o)
  );

endmodule

`default_nettype wire

// File: design/instBuffer.sv
`timescale 1ns/1ps
`default_nettype none

module instBuffer #(
  parameter int QUEUE_DEPTH    = frontEndPkg::DEF_QUEUE_DEPTH,
  parameter int FETCH_WIDTH    = frontEndPkg::DEF_FETCH_WIDTH,
  parameter int DISPATCH_WIDTH = frontEndPkg::DEF_DISPATCH_WIDTH,
  localparam int CNT_W = $clog2(FETCH_WIDTH + 1)
) (
  input  logic                                         clk,
  input  logic                                         rstN_i,
  input  logic                                         flush_i,
  input  logic                                         packValid_i,
  input  logic [CNT_W-1:0]                             packCount_i,
  input  logic [FETCH_WIDTH*frontEndPkg::PKT_W-1:0]    packData_i,
  input  logic                                         groupTake_i,
  output logic                                         groupReady_o,
  output logic [DISPATCH_WIDTH*frontEndPkg::PKT_W-1:0] groupData_o,
  output logic                                         fetchStall_o
);
  import frontEndPkg::*;

  localparam int ADDR_W  = $clog2(QUEUE_DEPTH);
  localparam int COUNT_W = ADDR_W + 1;
  // Room kept back for the bundle in the packer and the one behind it.
  localparam int STALL_LEVEL = QUEUE_DEPTH - 2 * FETCH_WIDTH;

  // Geometry check at elaboration.
  if ((QUEUE_DEPTH & (QUEUE_DEPTH - 1)) != 0 ||
      QUEUE_DEPTH < 2 * FETCH_WIDTH + DISPATCH_WIDTH) begin : gBadDepth
    $error("instBuffer: QUEUE_DEPTH must be a power of two, >= 2*FETCH_WIDTH+DISPATCH_WIDTH");
  end

  // Circular queue state.
  logic [ADDR_W-1:0]  headPtr;
  logic [ADDR_W-1:0]  tailPtr;
  logic [COUNT_W-1:0] count;
  logic [COUNT_W-1:0] countNext;

  // Storage port nets.
  logic [FETCH_WIDTH-1:0]           writeEn;
  logic [FETCH_WIDTH*ADDR_W-1:0]    writeAddr;
  logic [DISPATCH_WIDTH*ADDR_W-1:0] readAddr;

  // Write ports from the tail.
  // Only the first packCount ports fire.
  for (genvar p = 0; p < FETCH_WIDTH; p++) begin : gWrite
    assign writeAddr[p*ADDR_W +: ADDR_W] = tailPtr + ADDR_W'(p);
    assign writeEn[p] = packValid_i && (p < packCount_i);
  end

  // Read ports from the head.
  for (genvar r = 0; r < DISPATCH_WIDTH; r++) begin : gRead
    assign readAddr[r*ADDR_W +: ADDR_W] = headPtr + ADDR_W'(r);
  end

  instQueueRam #(
    .QUEUE_DEPTH   (QUEUE_DEPTH),
    .FETCH_WIDTH   (FETCH_WIDTH),
    .DISPATCH_WIDTH(DISPATCH_WIDTH)
  ) queueRam (
    .clk        (clk),
    .writeEn_i  (writeEn),
    .writeAddr_i(writeAddr),
    .writeData_i(packData_i),
    .readAddr_i (readAddr),
    .readData_o (groupData_o)
  );

  // Occupancy: add the incoming bundle, drop a taken group.
  always_comb begin
    countNext = count;
    if (packValid_i) begin
      countNext = countNext + COUNT_W'(packCount_i);
    end
    if (groupTake_i) begin
      countNext = countNext - COUNT_W'(DISPATCH_WIDTH);
    end
  end

  // Pointers and count.
  // Flush empties the queue at the next edge.
  always_ff @(posedge clk) begin
    if (!rstN_i || flush_i) begin
      headPtr <= '0;
      tailPtr <= '0;
      count   <= '0;
    end else begin
      if (packValid_i) begin
        tailPtr <= tailPtr + ADDR_W'(packCount_i);
      end
      if (groupTake_i) begin
        headPtr <= headPtr + ADDR_W'(DISPATCH_WIDTH);
      end
      count <= countNext;
    end
  end

  // Levels straight off the count register.
  assign groupReady_o = (count >= COUNT_W'(DISPATCH_WIDTH));
  assign fetchStall_o = (count > COUNT_W'(STALL_LEVEL));

  // Queue never overflows.
  assert property (@(posedge clk) disable iff (!rstN_i) count <= COUNT_W'(QUEUE_DEPTH))
    else $error("instBuffer: occupancy above QUEUE_DEPTH");

  // Fetch honoured the stall; the write trails the stall by the packer stage.
  assert property (@(posedge clk) disable iff (!rstN_i || flush_i)
    packValid_i |-> !$past(fetchStall_o, 2))
    else $error("instBuffer: bundle written after fetch stall, overflow");

  // Consumer only takes a full group.
  assert property (@(posedge clk) disable iff (!rstN_i) groupTake_i |-> groupReady_o)
    else $error("instBuffer: groupTake_i without groupReady_o");

endmodule

`default_nettype wire

// File: design/instQueueRam.sv
`timescale 1ns/1ps
`default_nettype none

module instQueueRam #(
  parameter int QUEUE_DEPTH    = frontEndPkg::DEF_QUEUE_DEPTH,
  parameter int FETCH_WIDTH    = frontEndPkg::DEF_FETCH_WIDTH,
  parameter int DISPATCH_WIDTH = frontEndPkg::DEF_DISPATCH_WIDTH,
  localparam int ADDR_W = $clog2(QUEUE_DEPTH)
) (
  input  logic                                         clk,
  input  logic [FETCH_WIDTH-1:0]                       writeEn_i,
  input  logic [FETCH_WIDTH*ADDR_W-1:0]                writeAddr_i,
  input  logic [FETCH_WIDTH*frontEndPkg::PKT_W-1:0]    writeData_i,
  input  logic [DISPATCH_WIDTH*ADDR_W-1:0]             readAddr_i,
  output logic [DISPATCH_WIDTH*frontEndPkg::PKT_W-1:0] readData_o
);
  import frontEndPkg::*;

  // Storage array.
  // Entry validity lives in the buffer pointers.
  logic [PKT_W-1:0] mem [QUEUE_DEPTH];

  // Write ports.
  // Addresses are consecutive from the tail, so never collide.
  always_ff @(posedge clk) begin
    for (int p = 0; p < FETCH_WIDTH; p++) begin
      if (writeEn_i[p]) begin
        mem[writeAddr_i[p*ADDR_W +: ADDR_W]] <= writeData_i[p*PKT_W +: PKT_W];
      end
    end
  end

  // Read ports, asynchronous.
  for (genvar r = 0; r < DISPATCH_WIDTH; r++) begin : gRead
    assign readData_o[r*PKT_W +: PKT_W] = mem[readAddr_i[r*ADDR_W +: ADDR_W]];
  end

endmodule

`default_nettype wire

// File: src.f
design/frontEndPkg.sv
design/decodePacker.sv
design/instQueueRam.sv
design/instBuffer.sv
design/dispatchGroup.sv
design/frontEndTop.sv
verif/tbFrontEnd.sv

// File: verif/tbFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module tbFrontEnd;
  import frontEndPkg::*;

  localparam int FETCH_WIDTH    = DEF_FETCH_WIDTH;
  localparam int DISPATCH_WIDTH = DEF_DISPATCH_WIDTH;
  localparam int QUEUE_DEPTH    = DEF_QUEUE_DEPTH;
  localparam int DCNT_W         = $clog2(DISPATCH_WIDTH + 1);
  localparam int NUM_ROWS       = 18;

  logic                                clk;
  logic                                rstN_i;
  logic                                flush_i;
  logic                                fetchValid_i;
  logic [FETCH_WIDTH-1:0]              fetchVector_i;
  logic [FETCH_WIDTH*OP_W-1:0]         fetchOp_i;
  logic [FETCH_WIDTH*PC_W-1:0]         fetchPc_i;
  logic [FETCH_WIDTH*IMM_W-1:0]        fetchImm_i;
  logic                                backendStall_i;
  logic                                fetchStall_o;
  logic                                dispatchValid_o;
  logic [DISPATCH_WIDTH*PKT_W-1:0]     dispatchData_o;
  logic [DCNT_W-1:0]                   branchCount_o;
  logic [DCNT_W-1:0]                   memCount_o;

  // One stimulus row: slot mask, strobe, back-end stall, flush, cycles.
  typedef struct packed {
    logic [FETCH_WIDTH-1:0] vec;
    logic                   fetch;
    logic                   bstall;
    logic                   flush;
    logic [7:0]             reps;
  } rowT;

  rowT stimTable [NUM_ROWS] = '{
    '{4'b1111, 1'b1, 1'b0, 1'b0, 8'd6},   // Full bundles, free flow.
    '{4'b1010, 1'b1, 1'b0, 1'b0, 8'd4},   // Holes in the bundle.
    '{4'b0001, 1'b1, 1'b0, 1'b0, 8'd3},
    '{4'b0000, 1'b0, 1'b0, 1'b0, 8'd6},
    '{4'b1111, 1'b1, 1'b1, 1'b0, 8'd3},   // Back-pressure.
    '{4'b0000, 1'b0, 1'b1, 1'b0, 8'd4},
    '{4'b0000, 1'b0, 1'b0, 1'b0, 8'd10},
    '{4'b1111, 1'b1, 1'b1, 1'b0, 8'd14},  // Long stall, buffer fills.
    '{4'b1111, 1'b1, 1'b0, 1'b0, 8'd6},
    '{4'b0000, 1'b0, 1'b0, 1'b0, 8'd12},
    '{4'b1111, 1'b1, 1'b0, 1'b0, 8'd3},
    '{4'b0000, 1'b0, 1'b0, 1'b1, 8'd2},   // Flush with work in flight.
    '{4'b0100, 1'b1, 1'b0, 1'b0, 8'd1},   // Single leftover instruction.
    '{4'b0000, 1'b0, 1'b0, 1'b0, 8'd5},
    '{4'b0001, 1'b1, 1'b0, 1'b0, 8'd1},
    '{4'b1011, 1'b1, 1'b0, 1'b0, 8'd3},
    '{4'b0000, 1'b0, 1'b0, 1'b1, 8'd1},
    '{4'b0000, 1'b0, 1'b0, 1'b0, 8'd12}
  };

  // Expected instruction stream, oldest first.
  logic [PKT_W-1:0] modelQ [$];
  logic [11:0]      seqNum;
  logic             stallSeen;
  int               stallRun;
  int               stallHits;
  int               groupsSeen;
  int               errorCount;
  int               cycleCount;
  int               cycleLimit;
  int unsigned      seedVal;

  frontEndTop #(
    .FETCH_WIDTH   (FETCH_WIDTH),
    .DISPATCH_WIDTH(DISPATCH_WIDTH),
    .QUEUE_DEPTH   (QUEUE_DEPTH)
  ) dut (
    .clk            (clk),
    .rstN_i         (rstN_i),
    .flush_i        (flush_i),
    .fetchValid_i   (fetchValid_i),
    .fetchVector_i  (fetchVector_i),
    .fetchOp_i      (fetchOp_i),
    .fetchPc_i      (fetchPc_i),
    .fetchImm_i     (fetchImm_i),
    .backendStall_i (backendStall_i),
    .fetchStall_o   (fetchStall_o),
    .dispatchValid_o(dispatchValid_o),
    .dispatchData_o (dispatchData_o),
    .branchCount_o  (branchCount_o),
    .memCount_o     (memCount_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic checkValue(input logic [63:0] actual, input logic [63:0] expected,
                            input string what);
    if (actual !== expected) begin
      errorCount++;
      $display("CHECK FAILED at %0t ns: %s (got %0h, expected %0h)",
               $time, what, actual, expected);
      $display("TEST FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // Drive one cycle of a row with fresh random payload.
  // Strobe held back on stall, or when the model could not take a full bundle.
  task automatic driveRow(input rowT row);
    logic                         doFetch;
    logic [FETCH_WIDTH*OP_W-1:0]  ops;
    logic [FETCH_WIDTH*PC_W-1:0]  pcs;
    logic [FETCH_WIDTH*IMM_W-1:0] imms;
    doFetch = row.fetch && !stallSeen && (modelQ.size() <= QUEUE_DEPTH - FETCH_WIDTH);
    for (int i = 0; i < FETCH_WIDTH; i++) begin
      ops[i*OP_W +: OP_W]    = OP_W'($urandom);
      pcs[i*PC_W +: PC_W]    = {seqNum, 4'($urandom)};
      imms[i*IMM_W +: IMM_W] = IMM_W'($urandom);
      seqNum++;
    end
    fetchValid_i   <= doFetch;
    fetchVector_i  <= row.vec;
    fetchOp_i      <= ops;
    fetchPc_i      <= pcs;
    fetchImm_i     <= imms;
    backendStall_i <= row.bstall;
    flush_i        <= row.flush;
  endtask

  // Output checks and model update, away from the clock edge.
  always @(negedge clk) begin : monitor
    logic [PKT_W-1:0] expPkt;
    int               expBranch;
    int               expMem;
    instOpE           op;
    if (rstN_i) begin
      if (fetchStall_o) stallHits++;
      stallRun = backendStall_i ? stallRun + 1 : 0;
      // First stalled cycle may still show the group taken just before.
      if (stallRun >= 2) checkValue(dispatchValid_o, 1'b0, "dispatch while back end stalled");
      if (dispatchValid_o) begin
        checkValue(modelQ.size() >= DISPATCH_WIDTH, 1'b1, "dispatch without a full group");
        expBranch = 0;
        expMem    = 0;
        for (int g = 0; g < DISPATCH_WIDTH; g++) begin
          expPkt = modelQ.pop_front();
          checkValue(dispatchData_o[g*PKT_W +: PKT_W], expPkt, "dispatched packet");
          op = instOpE'(expPkt[PKT_W-1 -: OP_W]);
          if (op == OP_BRANCH) expBranch++;
          if (op == OP_LOAD || op == OP_STORE) expMem++;
        end
        checkValue(branchCount_o, expBranch, "branch count");
        checkValue(memCount_o, expMem, "memory op count");
        groupsSeen++;
      end
      // Queue plus packer past one bundle of headroom needs the stall up.
      if (modelQ.size() > QUEUE_DEPTH - FETCH_WIDTH) begin
        checkValue(fetchStall_o, 1'b1, "fetch stall late for a filling queue");
      end
      // Flush drops everything fetched so far.
      if (flush_i) begin
        modelQ.delete();
      end else if (fetchValid_i) begin
        for (int i = 0; i < FETCH_WIDTH; i++) begin
          if (fetchVector_i[i]) begin
            modelQ.push_back({fetchOp_i[i*OP_W +: OP_W], fetchPc_i[i*PC_W +: PC_W],
                              fetchImm_i[i*IMM_W +: IMM_W]});
          end
        end
      end
    end
    stallSeen = fetchStall_o;
  end

  // Watchdog.
  always @(posedge clk) begin
    cycleCount++;
    if (cycleCount > cycleLimit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
      $display("TEST FAIL");
      $fatal(1, "stopped by watchdog");
    end
  end

  initial begin
    seedVal    = $urandom(81599);
    cycleLimit = 200;
    foreach (stimTable[r]) cycleLimit += stimTable[r].reps;
    seqNum = '0;
    stallSeen = 1'b0;
    rstN_i         <= 1'b0;
    flush_i        <= 1'b0;
    fetchValid_i   <= 1'b0;
    fetchVector_i  <= '0;
    fetchOp_i      <= '0;
    fetchPc_i      <= '0;
    fetchImm_i     <= '0;
    backendStall_i <= 1'b0;
    repeat (2) @(posedge clk);
    rstN_i <= 1'b1;
    @(negedge clk);
    checkValue(dispatchValid_o, 1'b0, "dispatchValid_o after reset");
    checkValue(fetchStall_o, 1'b0, "fetchStall_o after reset");
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int k = 0; k < stimTable[r].reps; k++) begin
        @(posedge clk);
        driveRow(stimTable[r]);
      end
    end
    // Idle until only a partial group is left.
    @(posedge clk);
    driveRow('{'0, 1'b0, 1'b0, 1'b0, 8'd1});
    while (modelQ.size() >= DISPATCH_WIDTH) @(posedge clk);
    repeat (6) @(posedge clk);
    checkValue(stallHits > 0, 1'b1, "fetch stall never rose");
    checkValue(groupsSeen > 0, 1'b1, "no group dispatched");
    if (errorCount == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
